//--- include/lsb_params.svh
`ifndef LSB_PARAMS_SVH
`define LSB_PARAMS_SVH

// queue geometry
`define LSB_DEPTH 16
`define LSB_PTR_W 4

// reorder buffer tag width
`define ROB_TAG_W 5

// data and address width
`define XLEN 32

// free entries left for the issue pipeline when full_o rises
`define LSB_FULL_SLACK 4

`endif

//--- hw/lsb_pkg.sv
`default_nettype none

`include "lsb_params.svh"

package lsb_pkg;

    // same encoding as the top-level op port
    typedef enum logic [3:0] {
        OP_LB  = 4'd0,
        OP_LH  = 4'd1,
        OP_LW  = 4'd2,
        OP_LBU = 4'd3,
        OP_LHU = 4'd4,
        OP_SB  = 4'd5,
        OP_SH  = 4'd6,
        OP_SW  = 4'd7
    } mem_op_e;

    // value is only meaningful once ready is set
    typedef struct packed {
        logic                  ready;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } operand_t;

    typedef struct packed {
        mem_op_e               op;
        logic [`ROB_TAG_W-1:0] rob;
        logic [`XLEN-1:0]      imm;
        operand_t              src1;
        operand_t              src2;
        logic                  committed;
    } lsb_entry_t;

    // access size in bytes
    typedef logic [2:0] mem_len_t;

    function automatic logic [`XLEN-1:0] format_load(input mem_op_e op,
                                                     input logic [`XLEN-1:0] raw);
        logic [`XLEN-1:0] res;
        case (op)
            OP_LB:   res = {{(`XLEN-8){raw[7]}}, raw[7:0]};
            OP_LH:   res = {{(`XLEN-16){raw[15]}}, raw[15:0]};
            OP_LBU:  res = {{(`XLEN-8){1'b0}}, raw[7:0]};
            OP_LHU:  res = {{(`XLEN-16){1'b0}}, raw[15:0]};
            default: res = raw;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

//--- hw/lsb_ptr_if.sv
`default_nettype none

`include "lsb_params.svh"

interface lsb_ptr_if;

    logic [`LSB_PTR_W-1:0] head_ptr;
    logic [`LSB_PTR_W-1:0] tail_ptr;
    logic                  empty;
    // entry written at tail this cycle
    logic                  alloc_fire;
    // head entry retires this cycle
    logic                  pop;

    modport ctrl (
        output head_ptr,
        output tail_ptr,
        output empty,
        output alloc_fire,
        input  pop
    );

    modport store (
        input head_ptr,
        input tail_ptr,
        input alloc_fire
    );

    modport issue (
        input  empty,
        output pop
    );

endinterface

`default_nettype wire

//--- hw/lsb_queue_ctrl.sv
`default_nettype none

`include "lsb_params.svh"

module lsb_queue_ctrl (
    input  wire logic  clk_in,
    input  wire logic  rst_in,
    input  wire logic  alloc_valid_i,
    input  wire logic  flush_i,
    input  wire logic  commit_valid_i,
    input  wire logic  commit_is_store_i,
    lsb_ptr_if.ctrl    ptr,
    output logic       full_o
);

    localparam int CNT_W = `LSB_PTR_W + 1;

    logic [`LSB_PTR_W-1:0] head_q;
    logic [`LSB_PTR_W-1:0] head_d;
    logic [`LSB_PTR_W-1:0] tail_q;
    logic [`LSB_PTR_W-1:0] tail_d;
    logic [CNT_W-1:0]      occ_q;
    logic [CNT_W-1:0]      occ_d;
    logic [CNT_W-1:0]      cmt_cnt_q;
    logic [CNT_W-1:0]      cmt_cnt_d;
    logic                  store_commit;
    logic                  cmt_pop;

    // allocation is dropped in a flush cycle
    assign ptr.alloc_fire = alloc_valid_i & ~flush_i;
    assign store_commit   = commit_valid_i & commit_is_store_i;

    // committed stores sit at the oldest end, so any pop while the
    // count is nonzero retires one of them
    assign cmt_pop = ptr.pop && (cmt_cnt_q != '0);

    always_comb begin
        head_d    = ptr.pop ? head_q + 1'b1 : head_q;
        cmt_cnt_d = cmt_cnt_q + CNT_W'(store_commit) - CNT_W'(cmt_pop);
        if (flush_i) begin
            // keep only the committed stores
            tail_d = head_d + cmt_cnt_d[`LSB_PTR_W-1:0];
            occ_d  = cmt_cnt_d;
        end else begin
            tail_d = ptr.alloc_fire ? tail_q + 1'b1 : tail_q;
            occ_d  = occ_q + CNT_W'(ptr.alloc_fire) - CNT_W'(ptr.pop);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head_q    <= '0;
            tail_q    <= '0;
            occ_q     <= '0;
            cmt_cnt_q <= '0;
            full_o    <= 1'b0;
        end else begin
            head_q    <= head_d;
            tail_q    <= tail_d;
            occ_q     <= occ_d;
            cmt_cnt_q <= cmt_cnt_d;
            full_o    <= occ_d >= CNT_W'(`LSB_DEPTH - `LSB_FULL_SLACK);
        end
    end

    assign ptr.head_ptr = head_q;
    assign ptr.tail_ptr = tail_q;
    assign ptr.empty    = (occ_q == '0);

    // store commits must only name entries that are still queued
    a_cmt_within_occ: assert property (@(posedge clk_in) disable iff (rst_in)
        cmt_cnt_q <= occ_q);

    // issue stage must stop on the early full flag
    a_no_alloc_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        !(alloc_valid_i && full_o));

endmodule

`default_nettype wire

//--- hw/lsb_entry_store.sv
`default_nettype none

`include "lsb_params.svh"

module lsb_entry_store (
    input  wire logic                  clk_in,
    input  wire logic                  rst_in,
    input  wire lsb_pkg::mem_op_e      alloc_op_i,
    input  wire logic [`ROB_TAG_W-1:0] alloc_rob_i,
    input  wire logic [`XLEN-1:0]      alloc_imm_i,
    input  wire lsb_pkg::operand_t     alloc_src1_i,
    input  wire lsb_pkg::operand_t     alloc_src2_i,
    input  wire logic                  commit_valid_i,
    input  wire logic [`ROB_TAG_W-1:0] commit_rob_i,
    input  wire logic [`XLEN-1:0]      commit_value_i,
    lsb_ptr_if.store                   ptr,
    output lsb_pkg::lsb_entry_t        head_entry_o
);

    import lsb_pkg::*;

    lsb_entry_t entries [`LSB_DEPTH];
    lsb_entry_t alloc_entry;

    // picks up the broadcast value if this operand waits on it
    function automatic operand_t wake_operand(input operand_t opnd);
        operand_t res;
        res = opnd;
        if (commit_valid_i && !opnd.ready && (opnd.tag == commit_rob_i)) begin
            res.ready = 1'b1;
            res.value = commit_value_i;
        end
        return res;
    endfunction

    // new entry, with bypass of a broadcast in the same cycle
    always_comb begin
        alloc_entry.op        = alloc_op_i;
        alloc_entry.rob       = alloc_rob_i;
        alloc_entry.imm       = alloc_imm_i;
        alloc_entry.src1      = wake_operand(alloc_src1_i);
        alloc_entry.src2      = wake_operand(alloc_src2_i);
        alloc_entry.committed = 1'b0;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            // clear the status bits
            for (int i = 0; i < `LSB_DEPTH; i++) begin
                entries[i].src1.ready <= 1'b0;
                entries[i].src2.ready <= 1'b0;
                entries[i].committed  <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `LSB_DEPTH; i++) begin
                if (ptr.alloc_fire && (i == int'(ptr.tail_ptr))) begin
                    entries[i] <= alloc_entry;
                end else begin
                    entries[i].src1 <= wake_operand(entries[i].src1);
                    entries[i].src2 <= wake_operand(entries[i].src2);
                    // the rob retiring this tag commits the entry
                    if (commit_valid_i && (entries[i].rob == commit_rob_i)) begin
                        entries[i].committed <= 1'b1;
                    end
                end
            end
        end
    end

    // stale slots may wake too but are overwritten on allocation
    assign head_entry_o = entries[ptr.head_ptr];

endmodule

`default_nettype wire

//--- hw/lsb_mem_issue.sv
`default_nettype none

`include "lsb_params.svh"

module lsb_mem_issue (
    input  wire logic                  clk_in,
    input  wire logic                  rst_in,
    input  wire logic                  flush_i,
    input  wire lsb_pkg::lsb_entry_t   head_entry_i,
    input  wire logic                  mem_done_i,
    input  wire logic [`XLEN-1:0]      mem_rdata_i,
    lsb_ptr_if.issue                   ptr,
    output logic                       mem_req_valid_o,
    output logic                       mem_we_o,
    output logic [`XLEN-1:0]           mem_addr_o,
    output logic [`XLEN-1:0]           mem_wdata_o,
    output lsb_pkg::mem_len_t          mem_len_o,
    output logic                       result_valid_o,
    output logic [`ROB_TAG_W-1:0]      result_rob_o,
    output logic [`XLEN-1:0]           result_value_o
);

    import lsb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESULT
    } state_e;

    state_e                state_q;
    mem_op_e               op_q;
    logic [`ROB_TAG_W-1:0] rob_q;
    logic                  flushed_q;
    logic                  head_is_store;
    logic                  head_ready;
    logic                  issue;
    logic                  load_dropped;
    mem_len_t              len_d;
    logic [`XLEN-1:0]      wdata_d;

    assign head_is_store = head_entry_i.op inside {OP_SB, OP_SH, OP_SW};

    // stores wait for commit and both operands, loads only for the base
    assign head_ready = head_is_store ?
        (head_entry_i.committed && head_entry_i.src1.ready && head_entry_i.src2.ready) :
        head_entry_i.src1.ready;

    assign issue = (state_q == ST_IDLE) && !ptr.empty && head_ready;

    // the flush already removed this load from the queue
    assign load_dropped = !mem_we_o && (flushed_q || flush_i);

    always_comb begin
        case (head_entry_i.op)
            OP_LB, OP_LBU, OP_SB: len_d = 3'd1;
            OP_LH, OP_LHU, OP_SH: len_d = 3'd2;
            default:              len_d = 3'd4;
        endcase
        case (head_entry_i.op)
            OP_SB:   wdata_d = {{(`XLEN-8){1'b0}}, head_entry_i.src2.value[7:0]};
            OP_SH:   wdata_d = {{(`XLEN-16){1'b0}}, head_entry_i.src2.value[15:0]};
            default: wdata_d = head_entry_i.src2.value;
        endcase
    end

    // loads retire on the done edge, stores one cycle later
    assign ptr.pop = ((state_q == ST_WAIT) && mem_done_i && !mem_we_o && !load_dropped) ||
                     ((state_q == ST_RESULT) && mem_we_o);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state_q         <= ST_IDLE;
            flushed_q       <= 1'b0;
            mem_req_valid_o <= 1'b0;
            mem_we_o        <= 1'b0;
            result_valid_o  <= 1'b0;
        end else begin
            mem_req_valid_o <= 1'b0;
            result_valid_o  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (issue) begin
                        mem_req_valid_o <= 1'b1;
                        mem_we_o        <= head_is_store;
                        mem_addr_o      <= head_entry_i.src1.value + head_entry_i.imm;
                        mem_wdata_o     <= wdata_d;
                        mem_len_o       <= len_d;
                        op_q            <= head_entry_i.op;
                        rob_q           <= head_entry_i.rob;
                        flushed_q       <= flush_i;
                        state_q         <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (flush_i) begin
                        flushed_q <= 1'b1;
                    end
                    if (mem_done_i) begin
                        result_valid_o <= !mem_we_o && !load_dropped;
                        result_rob_o   <= rob_q;
                        result_value_o <= format_load(op_q, mem_rdata_i);
                        state_q        <= ST_RESULT;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // one request at a time until the memory answers
    a_single_outstanding: assert property (@(posedge clk_in) disable iff (rst_in)
        mem_req_valid_o |=> (!mem_req_valid_o until_with mem_done_i));

endmodule

`default_nettype wire

//--- hw/lsb_top.sv
`default_nettype none

`include "lsb_params.svh"

module lsb_top (
    input  wire logic                  clk_in,
    input  wire logic                  rst_in,
    input  wire logic                  alloc_valid_i,
    input  wire logic [3:0]            alloc_op_i,
    input  wire logic [`ROB_TAG_W-1:0] alloc_rob_i,
    input  wire logic [`XLEN-1:0]      alloc_imm_i,
    input  wire logic                  alloc_src1_ready_i,
    input  wire logic [`ROB_TAG_W-1:0] alloc_src1_tag_i,
    input  wire logic [`XLEN-1:0]      alloc_src1_value_i,
    input  wire logic                  alloc_src2_ready_i,
    input  wire logic [`ROB_TAG_W-1:0] alloc_src2_tag_i,
    input  wire logic [`XLEN-1:0]      alloc_src2_value_i,
    input  wire logic                  commit_valid_i,
    input  wire logic [`ROB_TAG_W-1:0] commit_rob_i,
    input  wire logic [`XLEN-1:0]      commit_value_i,
    input  wire logic                  commit_is_store_i,
    input  wire logic                  flush_i,
    input  wire logic                  mem_done_i,
    input  wire logic [`XLEN-1:0]      mem_rdata_i,
    output logic                       full_o,
    output logic                       mem_req_valid_o,
    output logic                       mem_we_o,
    output logic [`XLEN-1:0]           mem_addr_o,
    output logic [`XLEN-1:0]           mem_wdata_o,
    output logic [2:0]                 mem_len_o,
    output logic                       result_valid_o,
    output logic [`ROB_TAG_W-1:0]      result_rob_o,
    output logic [`XLEN-1:0]           result_value_o
);

    import lsb_pkg::*;

    operand_t   alloc_src1;
    operand_t   alloc_src2;
    lsb_entry_t head_entry;

    assign alloc_src1 = '{ready: alloc_src1_ready_i, tag: alloc_src1_tag_i,
                          value: alloc_src1_value_i};
    assign alloc_src2 = '{ready: alloc_src2_ready_i, tag: alloc_src2_tag_i,
                          value: alloc_src2_value_i};

    lsb_ptr_if ptr_if ();

    lsb_queue_ctrl u_ctrl (
        .clk_in            (clk_in),
        .rst_in            (rst_in),
        .alloc_valid_i     (alloc_valid_i),
        .flush_i           (flush_i),
        .commit_valid_i    (commit_valid_i),
        .commit_is_store_i (commit_is_store_i),
        .ptr               (ptr_if.ctrl),
        .full_o            (full_o)
    );

    lsb_entry_store u_store (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .alloc_op_i     (mem_op_e'(alloc_op_i)),
        .alloc_rob_i    (alloc_rob_i),
        .alloc_imm_i    (alloc_imm_i),
        .alloc_src1_i   (alloc_src1),
        .alloc_src2_i   (alloc_src2),
        .commit_valid_i (commit_valid_i),
        .commit_rob_i   (commit_rob_i),
        .commit_value_i (commit_value_i),
        .ptr            (ptr_if.store),
        .head_entry_o   (head_entry)
    );

    lsb_mem_issue u_issue (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .flush_i         (flush_i),
        .head_entry_i    (head_entry),
        .mem_done_i      (mem_done_i),
        .mem_rdata_i     (mem_rdata_i),
        .ptr             (ptr_if.issue),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_we_o        (mem_we_o),
        .mem_addr_o      (mem_addr_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_len_o       (mem_len_o),
        .result_valid_o  (result_valid_o),
        .result_rob_o    (result_rob_o),
        .result_value_o  (result_value_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_lsb_top.sv
`default_nettype none

`include "lsb_params.svh"

module tb_lsb_top;

    import lsb_pkg::*;

    localparam int TEST_CYCLES    = 300;
    localparam int TIMEOUT_CYCLES = 6 * TEST_CYCLES + 1200;

    typedef struct {
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        mem_len_t         len;
        int               dones;
    } req_rec_t;

    typedef struct {
        logic [`ROB_TAG_W-1:0] rob;
        logic [`XLEN-1:0]      value;
    } result_rec_t;

    logic                  clk_in;
    logic                  rst_in;
    logic                  alloc_valid_i;
    logic [3:0]            alloc_op_i;
    logic [`ROB_TAG_W-1:0] alloc_rob_i;
    logic [`XLEN-1:0]      alloc_imm_i;
    logic                  alloc_src1_ready_i;
    logic [`ROB_TAG_W-1:0] alloc_src1_tag_i;
    logic [`XLEN-1:0]      alloc_src1_value_i;
    logic                  alloc_src2_ready_i;
    logic [`ROB_TAG_W-1:0] alloc_src2_tag_i;
    logic [`XLEN-1:0]      alloc_src2_value_i;
    logic                  commit_valid_i;
    logic [`ROB_TAG_W-1:0] commit_rob_i;
    logic [`XLEN-1:0]      commit_value_i;
    logic                  commit_is_store_i;
    logic                  flush_i;
    logic                  mem_done_i;
    logic [`XLEN-1:0]      mem_rdata_i;
    logic                  full_o;
    logic                  mem_req_valid_o;
    logic                  mem_we_o;
    logic [`XLEN-1:0]      mem_addr_o;
    logic [`XLEN-1:0]      mem_wdata_o;
    logic [2:0]            mem_len_o;
    logic                  result_valid_o;
    logic [`ROB_TAG_W-1:0] result_rob_o;
    logic [`XLEN-1:0]      result_value_o;

    req_rec_t         req_q [$];
    result_rec_t      res_q [$];
    logic [`XLEN-1:0] rdata_q [$];
    req_rec_t         req_rec;
    result_rec_t      res_rec;
    int               done_count = 0;
    int               cycle_count = 0;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    int               errors_at_start = 0;

    lsb_top uut (.*);

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (mem_req_valid_o) begin
                req_rec.we    = mem_we_o;
                req_rec.addr  = mem_addr_o;
                req_rec.wdata = mem_wdata_o;
                req_rec.len   = mem_len_o;
                req_rec.dones = done_count;
                req_q.push_back(req_rec);
            end
            if (mem_done_i) begin
                rdata_q.push_back(mem_rdata_i);
                done_count = done_count + 1;
            end
            if (result_valid_o) begin
                res_rec.rob   = result_rob_o;
                res_rec.value = result_value_o;
                res_q.push_back(res_rec);
            end
        end
    end

    task automatic tick();
        @(posedge clk_in);
        #2;
    endtask

    // memory model answering 1 to 4 cycles after each request
    task automatic answer_request();
        int unsigned delay;
        tick();
        if (mem_req_valid_o) begin
            delay = $urandom_range(4, 1);
            repeat (delay) tick();
            mem_done_i  = 1'b1;
            // byte and halfword sign bits set so every extension shows
            mem_rdata_i = $urandom | 32'h0000_8080;
            tick();
            mem_done_i = 1'b0;
        end
    endtask

    function automatic logic [`XLEN-1:0] expected_load(input mem_op_e op,
                                                       input logic [`XLEN-1:0] raw);
        case (op)
            OP_LB:   return `XLEN'($signed(raw[7:0]));
            OP_LH:   return `XLEN'($signed(raw[15:0]));
            OP_LBU:  return `XLEN'(raw[7:0]);
            OP_LHU:  return `XLEN'(raw[15:0]);
            default: return raw;
        endcase
    endfunction

    function automatic mem_len_t expected_len(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 3'd1;
            OP_LH, OP_LHU, OP_SH: return 3'd2;
            default:              return 3'd4;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] masked_store(input mem_op_e op,
                                                      input logic [`XLEN-1:0] data);
        case (op)
            OP_SB:   return data & 32'h0000_00ff;
            OP_SH:   return data & 32'h0000_ffff;
            default: return data;
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [`XLEN-1:0] got,
                                   input logic [`XLEN-1:0] exp);
        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        errors = errors + 1;
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    task automatic check_req(input logic exp_we, input logic [`XLEN-1:0] exp_addr,
                             input logic [`XLEN-1:0] exp_wdata, input mem_len_t exp_len,
                             input req_rec_t got);
        if (got.we !== exp_we)
            report_mismatch("request write enable", got.we, exp_we);
        if (got.addr !== exp_addr)
            report_mismatch("request address", got.addr, exp_addr);
        // write data only means something for stores
        if (exp_we && (got.wdata !== exp_wdata))
            report_mismatch("request write data", got.wdata, exp_wdata);
        if (got.len !== exp_len)
            report_mismatch("request length", got.len, exp_len);
    endtask

    task automatic check_result(input logic [`ROB_TAG_W-1:0] exp_rob,
                                input logic [`XLEN-1:0] exp_value, input result_rec_t got);
        if (got.rob !== exp_rob)
            report_mismatch("result rob tag", got.rob, exp_rob);
        if (got.value !== exp_value)
            report_mismatch("result value", got.value, exp_value);
    endtask

    task automatic check_flag(input logic exp_full, input string where);
        if (full_o !== exp_full)
            report_mismatch({"full flag ", where}, full_o, exp_full);
    endtask

    task automatic alloc_entry(input mem_op_e op, input logic [`ROB_TAG_W-1:0] rob,
                               input logic [`XLEN-1:0] imm, input logic r1,
                               input logic [`ROB_TAG_W-1:0] t1, input logic [`XLEN-1:0] v1,
                               input logic r2, input logic [`ROB_TAG_W-1:0] t2,
                               input logic [`XLEN-1:0] v2);
        alloc_valid_i      = 1'b1;
        alloc_op_i         = op;
        alloc_rob_i        = rob;
        alloc_imm_i        = imm;
        alloc_src1_ready_i = r1;
        alloc_src1_tag_i   = t1;
        alloc_src1_value_i = v1;
        alloc_src2_ready_i = r2;
        alloc_src2_tag_i   = t2;
        alloc_src2_value_i = v2;
        tick();
        alloc_valid_i = 1'b0;
    endtask

    task automatic broadcast(input logic [`ROB_TAG_W-1:0] rob, input logic [`XLEN-1:0] value,
                             input logic is_store);
        commit_valid_i    = 1'b1;
        commit_rob_i      = rob;
        commit_value_i    = value;
        commit_is_store_i = is_store;
        tick();
        commit_valid_i    = 1'b0;
        commit_is_store_i = 1'b0;
    endtask

    task automatic wait_for(input int n_done, input int n_res);
        while ((rdata_q.size() < n_done) || (res_q.size() < n_res))
            tick();
    endtask

    task automatic check_load(input mem_op_e op, input logic [`ROB_TAG_W-1:0] rob,
                              input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] raw;
        raw = rdata_q.pop_front();
        check_req(1'b0, addr, '0, expected_len(op), req_q.pop_front());
        if (res_q.size() == 0)
            report_error("load finished without a result");
        else
            check_result(rob, expected_load(op, raw), res_q.pop_front());
    endtask

    task automatic check_store(input mem_op_e op, input logic [`XLEN-1:0] addr,
                               input logic [`XLEN-1:0] data);
        void'(rdata_q.pop_front());
        check_req(1'b1, addr, masked_store(op, data), expected_len(op), req_q.pop_front());
    endtask

    task automatic quiet_check(input int cycles, input string msg);
        repeat (cycles) tick();
        if (req_q.size() != 0)
            report_error(msg);
    endtask

    // anything left over is an extra request or result
    task automatic end_test(input string name);
        repeat (10) tick();
        if (req_q.size() != 0)
            report_error("unexpected memory request");
        if (res_q.size() != 0)
            report_error("unexpected load result");
        req_q.delete();
        res_q.delete();
        rdata_q.delete();
        tests_run = tests_run + 1;
        if (errors != errors_at_start) begin
            tests_failed = tests_failed + 1;
            $display("test %s failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s passed", name);
        end
        errors_at_start = errors;
    endtask

    task automatic full_flag_test();
        logic [`XLEN-1:0] base;
        base = $urandom;
        check_flag(1'b0, "after reset");
        // uncommitted store keeps everything behind it
        alloc_entry(OP_SW, 5'd30, '0, 1'b1, '0, base, 1'b1, '0, 32'h1234_5678);
        for (int i = 0; i < 11; i++) begin
            alloc_entry(OP_LW, 5'(i), `XLEN'(4 * i), 1'b1, '0, base, 1'b0, '0, '0);
            if (i == 9)
                check_flag(1'b0, "with 11 entries");
        end
        check_flag(1'b1, "with 12 entries");
        broadcast(5'd30, '0, 1'b1);
        wait_for(12, 11);
        check_flag(1'b0, "after draining");
        check_store(OP_SW, base, 32'h1234_5678);
        for (int i = 0; i < 11; i++)
            check_load(OP_LW, 5'(i), base + `XLEN'(4 * i));
        end_test("full_flag");
    endtask

    task automatic load_formats_test();
        mem_op_e          ops [5];
        logic [`XLEN-1:0] base [5];
        logic [`XLEN-1:0] imm [5];
        ops = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
        for (int i = 0; i < 5; i++) begin
            base[i] = $urandom;
            imm[i]  = $urandom_range(255, 0);
            alloc_entry(ops[i], 5'(i), imm[i], 1'b1, '0, base[i], 1'b0, '0, '0);
        end
        wait_for(5, 5);
        for (int i = 0; i < 5; i++)
            check_load(ops[i], 5'(i), base[i] + imm[i]);
        end_test("load_formats");
    endtask

    task automatic load_wakeup_test();
        logic [`XLEN-1:0] v1;
        logic [`XLEN-1:0] v2;
        v1 = $urandom;
        v2 = $urandom;
        alloc_entry(OP_LW, 5'd8, 32'd16, 1'b0, 5'd20, '0, 1'b0, '0, '0);
        quiet_check(10, "load issued before its base was ready");
        broadcast(5'd20, v1, 1'b0);
        wait_for(1, 1);
        check_load(OP_LW, 5'd8, v1 + 32'd16);
        // broadcast in the allocation cycle
        commit_valid_i = 1'b1;
        commit_rob_i   = 5'd21;
        commit_value_i = v2;
        alloc_entry(OP_LHU, 5'd9, 32'd2, 1'b0, 5'd21, '0, 1'b0, '0, '0);
        commit_valid_i = 1'b0;
        wait_for(1, 1);
        check_load(OP_LHU, 5'd9, v2 + 32'd2);
        end_test("load_wakeup");
    endtask

    task automatic store_commit_test();
        mem_op_e          ops [3];
        logic [`XLEN-1:0] base;
        logic [`XLEN-1:0] data [3];
        ops  = '{OP_SB, OP_SH, OP_SW};
        base = $urandom;
        for (int i = 0; i < 3; i++) begin
            data[i] = $urandom;
            alloc_entry(ops[i], 5'(10 + i), `XLEN'(8 * i), 1'b1, '0, base, 1'b1, '0, data[i]);
        end
        quiet_check(10, "store issued before it was committed");
        for (int i = 0; i < 3; i++)
            broadcast(5'(10 + i), '0, 1'b1);
        wait_for(3, 0);
        for (int i = 0; i < 3; i++)
            check_store(ops[i], base + `XLEN'(8 * i), data[i]);
        end_test("store_commit");
    endtask

    task automatic program_order_test();
        logic [`XLEN-1:0] base;
        base = $urandom;
        alloc_entry(OP_SW, 5'd13, '0, 1'b1, '0, base, 1'b1, '0, 32'hcafe_f00d);
        alloc_entry(OP_LBU, 5'd14, 32'd1, 1'b1, '0, base, 1'b0, '0, '0);
        quiet_check(10, "younger load passed an uncommitted store");
        broadcast(5'd13, '0, 1'b1);
        wait_for(2, 1);
        if (req_q[1].dones != req_q[0].dones + 1)
            report_error("load request came before the store was done");
        check_store(OP_SW, base, 32'hcafe_f00d);
        check_load(OP_LBU, 5'd14, base + 32'd1);
        end_test("program_order");
    endtask

    task automatic flush_test();
        logic [`XLEN-1:0] base;
        base = $urandom;
        alloc_entry(OP_SW, 5'd15, 32'd4, 1'b1, '0, base, 1'b1, '0, 32'h0bad_beef);
        alloc_entry(OP_SB, 5'd16, 32'd8, 1'b1, '0, base, 1'b1, '0, 32'h5555_aaaa);
        alloc_entry(OP_LW, 5'd17, '0, 1'b0, 5'd25, '0, 1'b0, '0, '0);
        alloc_entry(OP_SH, 5'd18, '0, 1'b1, '0, base, 1'b1, '0, 32'h1357_9bdf);
        repeat (2) tick();
        // first store in flight and second still queued when the flush comes
        broadcast(5'd15, '0, 1'b1);
        broadcast(5'd16, '0, 1'b1);
        flush_i = 1'b1;
        tick();
        flush_i = 1'b0;
        // would wake the dropped load if it were still queued
        broadcast(5'd25, $urandom, 1'b0);
        wait_for(2, 0);
        check_store(OP_SW, base + 32'd4, 32'h0bad_beef);
        check_store(OP_SB, base + 32'd8, 32'h5555_aaaa);
        end_test("flush");
    endtask

    initial begin
        void'($urandom(83));
        rst_in             = 1'b1;
        alloc_valid_i      = 1'b0;
        alloc_op_i         = '0;
        alloc_rob_i        = '0;
        alloc_imm_i        = '0;
        alloc_src1_ready_i = 1'b0;
        alloc_src1_tag_i   = '0;
        alloc_src1_value_i = '0;
        alloc_src2_ready_i = 1'b0;
        alloc_src2_tag_i   = '0;
        alloc_src2_value_i = '0;
        commit_valid_i     = 1'b0;
        commit_rob_i       = '0;
        commit_value_i     = '0;
        commit_is_store_i  = 1'b0;
        flush_i            = 1'b0;
        mem_done_i         = 1'b0;
        mem_rdata_i        = '0;
        // memory model runs beside the tests
        fork
            forever answer_request();
        join_none
        repeat (8) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
        full_flag_test();
        load_formats_test();
        load_wakeup_test();
        store_commit_test();
        program_order_test();
        flush_test();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
hw/lsb_pkg.sv
hw/lsb_ptr_if.sv
hw/lsb_queue_ctrl.sv
hw/lsb_entry_store.sv
hw/lsb_mem_issue.sv
hw/lsb_top.sv
verif/tb_lsb_top.sv
